/* qu_rename_defines.svh */
/*
 * Register counts and address widths for the rename slice
 */

`ifndef QU_RENAME_DEFINES_SVH
`define QU_RENAME_DEFINES_SVH

// Architectural register file
`define QU_LOG_REGS     32
`define QU_LOG_ADDR_W   5

// Physical register file
`define QU_PHY_REGS     64
`define QU_PHY_ADDR_W   6

// One free list slot per physical register
`define QU_FREE_DEPTH   `QU_PHY_REGS

`endif

/* qu_rename_pkg.sv */
/*
 * Register address types and the dispatch output state
 */

`include "qu_rename_defines.svh"

package qu_rename_pkg;

    // Architectural register name, x0 to x31
    typedef logic [`QU_LOG_ADDR_W-1:0] log_reg_t;

    // Physical register name
    typedef logic [`QU_PHY_ADDR_W-1:0] phy_reg_t;

    // Renamed output register
    typedef enum logic {
        IDLE,
        ISSUED
    } dispatch_state_t;

endpackage

/* rename_if.sv */
/*
 * map_lookup_if between map table and dispatch,
 * preg_alloc_if between free list and dispatch
 */

`timescale 1ns/100ps

interface map_lookup_if;

    // Lookup request and combinational answers
    qu_rename_pkg::log_reg_t rs1;
    qu_rename_pkg::log_reg_t rs2;
    qu_rename_pkg::log_reg_t rd;
    qu_rename_pkg::phy_reg_t prs1;
    qu_rename_pkg::phy_reg_t prs2;
    qu_rename_pkg::phy_reg_t old_prd;

    // New mapping for the destination
    logic                    wr_en;
    qu_rename_pkg::log_reg_t wr_rd;
    qu_rename_pkg::phy_reg_t wr_prd;

    modport map_table (
        input  rs1, rs2, rd, wr_en, wr_rd, wr_prd,
        output prs1, prs2, old_prd
    );

    modport client (
        output rs1, rs2, rd, wr_en, wr_rd, wr_prd,
        input  prs1, prs2, old_prd
    );

endinterface

interface preg_alloc_if;

    logic                    empty;
    qu_rename_pkg::phy_reg_t head_preg;
    logic                    pop;

    modport pool (
        output empty, head_preg,
        input  pop
    );

    modport client (
        input  empty, head_preg,
        output pop
    );

endinterface

/* rename_map.sv */
/*
 * Rename map table, logical to physical register,
 * three combinational reads and one write port
 */

`timescale 1ns/100ps

`include "qu_rename_defines.svh"

module rename_map (
    input   logic clk,
    input   logic rst_n,
    map_lookup_if.map_table lookup
);

    qu_rename_pkg::phy_reg_t map_q [`QU_LOG_REGS];

    // Identity mapping out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `QU_LOG_REGS; i++) begin
                map_q[i] <= qu_rename_pkg::phy_reg_t'(i);
            end
        end else if (lookup.wr_en) begin
            map_q[lookup.wr_rd] <= lookup.wr_prd;
        end
    end

    // Reads see the table before this cycle's write
    assign lookup.prs1    = map_q[lookup.rs1];
    assign lookup.prs2    = map_q[lookup.rs2];
    assign lookup.old_prd = map_q[lookup.rd];

    // x0 keeps physical register 0 for good
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        lookup.wr_en |-> (lookup.wr_rd != '0)
    ) else $error("rename_map: write to x0 mapping");

endmodule

/* free_list.sv */
/*
 * Free list of physical registers as a circular queue,
 * popped on allocation and pushed on retire
 */

`timescale 1ns/100ps

`include "qu_rename_defines.svh"

module free_list (
    input   logic clk,
    input   logic rst_n,
    preg_alloc_if.pool alloc,
    input   logic free_en,
    input   qu_rename_pkg::phy_reg_t free_preg
);

    qu_rename_pkg::phy_reg_t fifo_q [`QU_FREE_DEPTH];
    qu_rename_pkg::phy_reg_t head_q;
    qu_rename_pkg::phy_reg_t tail_q;
    logic [`QU_PHY_ADDR_W:0] count_q;
    logic                    full;

    // Registers above the architectural ones start out free
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `QU_FREE_DEPTH; i++) begin
                // Upper half wraps around, not valid until pushed
                fifo_q[i] <= qu_rename_pkg::phy_reg_t'(i + `QU_LOG_REGS);
            end
        end else if (free_en) begin
            fifo_q[tail_q] <= free_preg;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= qu_rename_pkg::phy_reg_t'(`QU_LOG_REGS);
            count_q <= {1'b0, qu_rename_pkg::phy_reg_t'(`QU_LOG_REGS)};
        end else begin
            if (free_en) begin
                tail_q <= tail_q + 1'b1;
            end
            if (alloc.pop) begin
                head_q <= head_q + 1'b1;
            end
            case ({free_en, alloc.pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Count MSB only set at the full depth
    assign full = count_q[`QU_PHY_ADDR_W];

    assign alloc.empty     = (count_q == '0);
    assign alloc.head_preg = fifo_q[head_q];

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        alloc.pop |-> !alloc.empty
    ) else $error("free_list: pop while empty");

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        free_en |-> !full
    ) else $error("free_list: push while full");

endmodule

/* rename_dispatch.sv */
/*
 * Rename dispatch with stall, busy table and
 * the registered renamed micro-op
 */

`timescale 1ns/100ps

`include "qu_rename_defines.svh"

module rename_dispatch (
    input   logic clk,
    input   logic rst_n,
    map_lookup_if.client lookup,
    preg_alloc_if.client alloc,

    input   logic in_valid,
    input   qu_rename_pkg::log_reg_t in_rs1,
    input   qu_rename_pkg::log_reg_t in_rs2,
    input   qu_rename_pkg::log_reg_t in_rd,

    input   logic wb_en,
    input   qu_rename_pkg::phy_reg_t wb_preg,
    input   logic res_full,

    output  logic stall,
    output  logic out_valid,
    output  qu_rename_pkg::phy_reg_t out_prs1,
    output  logic out_prs1_busy,
    output  qu_rename_pkg::phy_reg_t out_prs2,
    output  logic out_prs2_busy,
    output  qu_rename_pkg::phy_reg_t out_prd,
    output  qu_rename_pkg::phy_reg_t out_old_prd,
    output  logic out_has_rd
);

    logic                           has_rd;
    logic                           accept;
    logic                           alloc_en;
    logic                           prs1_busy;
    logic                           prs2_busy;
    logic [`QU_PHY_REGS-1:0]        busy_q;
    qu_rename_pkg::dispatch_state_t state_q;

    assign has_rd = (in_rd != '0);

    // No free register needed for x0
    assign stall    = res_full || (has_rd && alloc.empty);
    assign accept   = in_valid && !stall;
    assign alloc_en = accept && has_rd;

    assign lookup.rs1    = in_rs1;
    assign lookup.rs2    = in_rs2;
    assign lookup.rd     = in_rd;
    assign lookup.wr_en  = alloc_en;
    assign lookup.wr_rd  = in_rd;
    assign lookup.wr_prd = alloc.head_preg;
    assign alloc.pop     = alloc_en;

    // Writeback this cycle counts as already done, p0 never busy
    assign prs1_busy = busy_q[lookup.prs1] && (lookup.prs1 != '0)
                       && !(wb_en && (wb_preg == lookup.prs1));
    assign prs2_busy = busy_q[lookup.prs2] && (lookup.prs2 != '0)
                       && !(wb_en && (wb_preg == lookup.prs2));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else begin
            if (wb_en) begin
                busy_q[wb_preg] <= 1'b0;
            end
            if (alloc_en) begin
                busy_q[alloc.head_preg] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= qu_rename_pkg::IDLE;
        end else begin
            state_q <= accept ? qu_rename_pkg::ISSUED : qu_rename_pkg::IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_prs1      <= lookup.prs1;
            out_prs1_busy <= prs1_busy;
            out_prs2      <= lookup.prs2;
            out_prs2_busy <= prs2_busy;
            out_prd       <= has_rd ? alloc.head_preg : '0;
            out_old_prd   <= has_rd ? lookup.old_prd : '0;
            out_has_rd    <= has_rd;
        end
    end

    assign out_valid = (state_q == qu_rename_pkg::ISSUED);

    a_no_issue_after_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |=> !out_valid
    ) else $error("rename_dispatch: out_valid after stalled cycle");

endmodule

/* qu_rename_top.sv */
/*
 * Register rename slice top level
 */

`timescale 1ns/100ps

module qu_rename_top (
    input   logic clk,
    input   logic rst_n,

    input   logic in_valid,
    input   qu_rename_pkg::log_reg_t in_rs1,
    input   qu_rename_pkg::log_reg_t in_rs2,
    input   qu_rename_pkg::log_reg_t in_rd,

    input   logic wb_en,
    input   qu_rename_pkg::phy_reg_t wb_preg,
    input   logic free_en,
    input   qu_rename_pkg::phy_reg_t free_preg,
    input   logic res_full,

    output  logic stall,
    output  logic out_valid,
    output  qu_rename_pkg::phy_reg_t out_prs1,
    output  logic out_prs1_busy,
    output  qu_rename_pkg::phy_reg_t out_prs2,
    output  logic out_prs2_busy,
    output  qu_rename_pkg::phy_reg_t out_prd,
    output  qu_rename_pkg::phy_reg_t out_old_prd,
    output  logic out_has_rd
);

    map_lookup_if lookup_bus ();
    preg_alloc_if alloc_bus ();

    rename_map qu_map (
        .clk(clk),
        .rst_n(rst_n),
        .lookup(lookup_bus)
    );

    free_list qu_free_list (
        .clk(clk),
        .rst_n(rst_n),
        .alloc(alloc_bus),
        .free_en(free_en),
        .free_preg(free_preg)
    );

    rename_dispatch qu_dispatch (
        .clk(clk),
        .rst_n(rst_n),
        .lookup(lookup_bus),
        .alloc(alloc_bus),
        .in_valid(in_valid),
        .in_rs1(in_rs1),
        .in_rs2(in_rs2),
        .in_rd(in_rd),
        .wb_en(wb_en),
        .wb_preg(wb_preg),
        .res_full(res_full),
        .stall(stall),
        .out_valid(out_valid),
        .out_prs1(out_prs1),
        .out_prs1_busy(out_prs1_busy),
        .out_prs2(out_prs2),
        .out_prs2_busy(out_prs2_busy),
        .out_prd(out_prd),
        .out_old_prd(out_old_prd),
        .out_has_rd(out_has_rd)
    );

endmodule

/* tb_qu_rename.sv */
/*
 * Testbench for the rename slice, replays golden vectors
 * and compares stall and renamed outputs
 */

`timescale 1ns/100ps

module tb_qu_rename;

    localparam int MAX_VECTORS = 128;
    localparam int NUM_FIELDS  = 18;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    qu_rename_pkg::log_reg_t in_rs1;
    qu_rename_pkg::log_reg_t in_rs2;
    qu_rename_pkg::log_reg_t in_rd;
    logic                    wb_en;
    qu_rename_pkg::phy_reg_t wb_preg;
    logic                    free_en;
    qu_rename_pkg::phy_reg_t free_preg;
    logic                    res_full;
    logic                    stall;
    logic                    out_valid;
    qu_rename_pkg::phy_reg_t out_prs1;
    logic                    out_prs1_busy;
    qu_rename_pkg::phy_reg_t out_prs2;
    logic                    out_prs2_busy;
    qu_rename_pkg::phy_reg_t out_prd;
    qu_rename_pkg::phy_reg_t out_old_prd;
    logic                    out_has_rd;

    // Columns 0..8 inputs, 9..17 expected results
    logic [7:0] golden [MAX_VECTORS][NUM_FIELDS];
    int         num_vectors;
    int         errors;
    int         cycle_count;
    int         cycle_limit;
    logic       loaded;

    qu_rename_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic load_golden();
        int                 fd;
        int                 n;
        int                 f [NUM_FIELDS];
        logic [8*256-1:0]   text;
        fd = $fopen("qu_rename_golden.txt", "r");
        if (fd == 0) begin
            $display("Golden file qu_rename_golden.txt could not be opened");
            errors++;
            return;
        end
        while (!$feof(fd) && num_vectors < MAX_VECTORS) begin
            text = '0;
            if ($fgets(text, fd) != 0) begin
                n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                            f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
                // Comment and blank lines give no fields
                if (n == NUM_FIELDS) begin
                    for (int k = 0; k < NUM_FIELDS; k++) begin
                        golden[num_vectors][k] = f[k][7:0];
                    end
                    num_vectors++;
                end else if (n > 0) begin
                    $display("Golden line after vector %0d is short, %0d of %0d fields",
                             num_vectors, n, NUM_FIELDS);
                    errors++;
                end
            end
        end
        $fclose(fd);
        if (num_vectors == 0) begin
            $display("Golden file holds no vectors");
            errors++;
        end
    endtask

    task automatic clear_inputs();
        in_valid  = 1'b0;
        in_rs1    = '0;
        in_rs2    = '0;
        in_rd     = '0;
        wb_en     = 1'b0;
        wb_preg   = '0;
        free_en   = 1'b0;
        free_preg = '0;
        res_full  = 1'b0;
    endtask

    task automatic apply_vector(input int i);
        in_valid  = golden[i][0][0];
        in_rs1    = golden[i][1][4:0];
        in_rs2    = golden[i][2][4:0];
        in_rd     = golden[i][3][4:0];
        wb_en     = golden[i][4][0];
        wb_preg   = golden[i][5][5:0];
        free_en   = golden[i][6][0];
        free_preg = golden[i][7][5:0];
        res_full  = golden[i][8][0];
    endtask

    task automatic compare_field(input string name, input logic [7:0] got,
                                 input logic [7:0] exp, input int vec);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: vector %0d %s is %h, expected %h",
                     $time, vec, name, got, exp);
        end
    endtask

    task automatic check_stall(input int i);
        compare_field("stall", 8'(stall), golden[i][9], i);
    endtask

    // Fields only matter when out_valid is expected
    task automatic verify_renamed(input int i);
        compare_field("out_valid", 8'(out_valid), golden[i][10], i);
        if (golden[i][10][0]) begin
            compare_field("out_prs1", 8'(out_prs1), golden[i][11], i);
            compare_field("out_prs1_busy", 8'(out_prs1_busy), golden[i][12], i);
            compare_field("out_prs2", 8'(out_prs2), golden[i][13], i);
            compare_field("out_prs2_busy", 8'(out_prs2_busy), golden[i][14], i);
            compare_field("out_prd", 8'(out_prd), golden[i][15], i);
            compare_field("out_old_prd", 8'(out_old_prd), golden[i][16], i);
            compare_field("out_has_rd", 8'(out_has_rd), golden[i][17], i);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        errors      = 0;
        num_vectors = 0;
        loaded      = 1'b0;
        clear_inputs();
        load_golden();
        if (errors != 0) begin
            $display("Run aborted, golden file unusable");
        end else begin
            loaded = 1'b1;
            repeat (5) @(posedge clk);
            #1 rst_n = 1'b1;
            // Stall checked late in the cycle, outputs one cycle later
            for (int i = 0; i < num_vectors; i++) begin
                @(posedge clk);
                #1;
                apply_vector(i);
                #8;
                check_stall(i);
                if (i > 0) begin
                    verify_renamed(i - 1);
                end
            end
            @(posedge clk);
            #1;
            clear_inputs();
            #8;
            verify_renamed(num_vectors - 1);
        end
        $display("Checked %0d vectors, %0d errors", num_vectors, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        wait (loaded);
        cycle_limit = num_vectors + 20;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout, run still going after %0d cycles", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* qu_rename_golden.txt */
# in: valid rs1 rs2 rd wb_en wb_preg free_en free_preg res_full
# exp: stall out_valid prs1 prs1_busy prs2 prs2_busy prd old_prd has_rd
1 01 02 03 0 00 0 00 0  0 1 01 0 02 0 20 03 1
1 04 05 06 0 00 0 00 0  0 1 04 0 05 0 21 06 1
1 07 08 09 0 00 0 00 0  0 1 07 0 08 0 22 09 1
1 09 03 0a 0 00 0 00 0  0 1 22 1 20 1 23 0a 1
1 0a 06 0b 1 23 0 00 0  0 1 23 0 21 1 24 0b 1
1 0a 00 0c 0 00 0 00 0  0 1 23 0 00 0 25 0c 1
1 0b 0c 00 0 00 0 00 0  0 1 24 1 25 1 00 00 0
1 01 01 0d 0 00 0 00 0  0 1 01 0 01 0 26 0d 1
0 00 00 00 0 00 0 00 0  0 0 00 0 00 0 00 00 0
1 00 00 0e 0 00 0 00 0  0 1 00 0 00 0 27 0e 1
1 00 00 0f 0 00 0 00 0  0 1 00 0 00 0 28 0f 1
1 00 00 10 0 00 0 00 0  0 1 00 0 00 0 29 10 1
1 00 00 11 0 00 0 00 0  0 1 00 0 00 0 2a 11 1
1 00 00 12 0 00 0 00 0  0 1 00 0 00 0 2b 12 1
1 00 00 13 0 00 0 00 0  0 1 00 0 00 0 2c 13 1
1 00 00 14 0 00 0 00 0  0 1 00 0 00 0 2d 14 1
1 00 00 15 0 00 0 00 0  0 1 00 0 00 0 2e 15 1
1 00 00 16 0 00 0 00 0  0 1 00 0 00 0 2f 16 1
1 00 00 17 0 00 0 00 0  0 1 00 0 00 0 30 17 1
1 00 00 18 0 00 0 00 0  0 1 00 0 00 0 31 18 1
1 00 00 19 0 00 0 00 0  0 1 00 0 00 0 32 19 1
1 00 00 1a 0 00 0 00 0  0 1 00 0 00 0 33 1a 1
1 00 00 1b 0 00 0 00 0  0 1 00 0 00 0 34 1b 1
1 00 00 1c 0 00 0 00 0  0 1 00 0 00 0 35 1c 1
1 00 00 1d 0 00 0 00 0  0 1 00 0 00 0 36 1d 1
1 00 00 1e 0 00 0 00 0  0 1 00 0 00 0 37 1e 1
1 00 00 1f 0 00 0 00 0  0 1 00 0 00 0 38 1f 1
1 00 00 01 0 00 0 00 0  0 1 00 0 00 0 39 01 1
1 00 00 02 0 00 0 00 0  0 1 00 0 00 0 3a 02 1
1 00 00 04 0 00 0 00 0  0 1 00 0 00 0 3b 04 1
1 00 00 05 0 00 0 00 0  0 1 00 0 00 0 3c 05 1
1 00 00 07 0 00 0 00 0  0 1 00 0 00 0 3d 07 1
1 00 00 08 0 00 0 00 0  0 1 00 0 00 0 3e 08 1
1 00 00 03 0 00 0 00 0  0 1 00 0 00 0 3f 20 1
1 01 02 09 0 00 0 00 0  1 0 00 0 00 0 00 00 0
1 01 02 00 0 00 0 00 0  0 1 39 1 3a 1 00 00 0
0 00 00 05 0 00 0 00 0  1 0 00 0 00 0 00 00 0
1 00 00 05 0 00 1 20 0  1 0 00 0 00 0 00 00 0
1 04 00 05 0 00 1 03 0  0 1 3b 1 00 0 20 3c 1
1 05 03 07 0 00 0 00 0  0 1 20 1 3f 1 03 3d 1
1 00 00 08 0 00 0 00 0  1 0 00 0 00 0 00 00 0
0 00 00 00 0 00 1 06 0  0 0 00 0 00 0 00 00 0
1 01 02 0a 0 00 0 00 1  1 0 00 0 00 0 00 00 0
1 01 02 00 0 00 0 00 1  1 0 00 0 00 0 00 00 0
0 00 00 0a 1 24 1 09 1  1 0 00 0 00 0 00 00 0
1 0b 0a 0a 0 00 0 00 0  0 1 24 0 23 0 06 23 1
1 0a 0e 0e 0 00 0 00 0  0 1 06 1 27 1 09 27 1
0 00 00 0f 0 00 0 00 0  1 0 00 0 00 0 00 00 0

/* qu_rename.f */
+incdir+.
qu_rename_pkg.sv
rename_if.sv
rename_map.sv
free_list.sv
rename_dispatch.sv
qu_rename_top.sv
tb_qu_rename.sv

/* Makefile */
# Verilator build and run for the rename slice

VERILATOR ?= verilator
TOP       ?= tb_qu_rename
FILELIST  ?= qu_rename.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
